// File: dv/spiMemoryTb.sv
// self-checking testbench for the SPI memory that bit-bangs the transactions listed in the tests file
`timescale 1ns/10ps

module spiMemoryTb;

    localparam int addrWidth  = 7;
    localparam int waitCycles = 3;
    // system clocks in one sclk half period
    localparam int halfPeriod = 12;
    // watchdog budget per test line
    localparam int cyclesPerLine = 500;

    logic clk;
    logic reset;
    logic sclk;
    logic csN;
    logic mosi;
    logic miso;
    logic misoEnable;

    // reference copy of the memory that follows every completed write
    logic [7:0] refMem [1 << addrWidth];

    // test lines as loaded from the file
    logic [7:0]           opList   [$];
    logic [addrWidth-1:0] addrList [$];
    logic [7:0]           dataList [$];
    int                   abortList[$];

    logic [31:0] lfsrState;
    logic        testsLoaded;
    int          errorCount;
    int          checkCount;
    int          timeoutCycles;

    spiMemory #(
        .addrWidth (addrWidth),
        .waitCycles(waitCycles)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .sclk      (sclk),
        .csN       (csN),
        .mosi      (mosi),
        .miso      (miso),
        .misoEnable(misoEnable)
    );

    // 8 ns system clock
    always #4 clk = ~clk;

    // wait for some rising edges, then step 1 ns past the last one
    task automatic idleClocks(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // idle gap of 4 to 19 clocks with one LFSR step per bit
    task automatic idleGap();
        logic [3:0] nibble;
        int         bitIndex;
        nibble = '0;
        for (bitIndex = 0; bitIndex < 4; bitIndex++) begin
            lfsrState = lfsrNext(lfsrState);
            nibble    = {nibble[2:0], lfsrState[31]};
        end
        idleClocks(4 + nibble);
    endtask

    task automatic checkMisoEnable(input logic expected, input string where);
        checkCount++;
        assert (misoEnable === expected) else begin
            errorCount++;
            $display("Fail misoEnable %s: expected %h, actual %h", where, expected, misoEnable);
        end
    endtask

    // columns are op letter, address in hex, data in hex and abort bit count
    task automatic loadTests();
        int                   fd;
        int                   code;
        int                   ch;
        logic [7:0]           opChar;
        logic [addrWidth-1:0] addrVal;
        logic [7:0]           dataVal;
        int                   abortVal;
        logic                 knownOp;
        fd = $fopen("dv/spiMemoryTests.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the tests file dv/spiMemoryTests.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", opChar);
                if (code == 1) begin
                    if (opChar == "#") begin
                        // comment line is skipped up to its newline
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end else begin
                        code    = $fscanf(fd, " %h %h %d", addrVal, dataVal, abortVal);
                        knownOp = (opChar == "W") || (opChar == "R") ||
                                  (opChar == "A") || (opChar == "G");
                        if (code != 3 || !knownOp) begin
                            errorCount++;
                            $display("malformed test line starting with %c", opChar);
                        end else begin
                            opList.push_back(opChar);
                            addrList.push_back(addrVal);
                            dataList.push_back(dataVal);
                            abortList.push_back(abortVal);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one full SPI mode 0 transaction, master side
    task automatic runTransaction(
        input logic [7:0]           op,
        input logic [addrWidth-1:0] addr,
        input logic [7:0]           data,
        input int                   abortBits
    );
        logic [15:0] frame;
        logic [7:0]  readByte;
        logic        isRead;
        logic        glitch;
        int          bitLimit;
        int          i;
        isRead   = (op == "R");
        glitch   = (op == "G");
        bitLimit = (op == "A") ? abortBits : 16;
        // address goes MSB first, followed by rw and then data (zeros on a read)
        frame    = isRead ? {addr, 1'b1, 8'h00} : {addr, 1'b0, data};
        readByte = '0;
        csN = 1'b0;
        for (i = 0; i < bitLimit; i++) begin
            // mosi moves shortly after sclk falls in the low half
            idleClocks(2);
            mosi = frame[15 - i];
            idleClocks(halfPeriod - 2);
            // sample just before the rising edge
            checkMisoEnable(isRead && i >= 8, $sformatf("at bit %0d of %c %h", i, op, addr));
            if (isRead && i >= 8) begin
                readByte = {readByte[6:0], miso};
            end
            sclk = 1'b1;
            if (glitch) begin
                // single-clock pulses on sclk and mosi in the middle of the high half
                idleClocks(6);
                sclk = 1'b0;
                mosi = ~mosi;
                idleClocks(1);
                sclk = 1'b1;
                mosi = ~mosi;
                idleClocks(halfPeriod - 7);
            end else begin
                idleClocks(halfPeriod);
            end
            sclk = 1'b0;
        end
        idleClocks(halfPeriod);
        csN = 1'b1;
        if (isRead) begin
            checkCount++;
            assert (readByte === refMem[addr]) else begin
                errorCount++;
                $display("Fail miso byte at address %h: expected %h, actual %h",
                         addr, refMem[addr], readByte);
            end
        end else if (op != "A") begin
            refMem[addr] = data;
        end
        // csN has been high for a full half period here
        idleClocks(halfPeriod);
        checkMisoEnable(1'b0, $sformatf("after csN release of %c %h", op, addr));
        idleGap();
    endtask

    // watchdog sized from the number of test lines plus one line's worth for reset
    initial begin
        wait (testsLoaded);
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        sclk        = 1'b0;
        csN         = 1'b1;
        mosi        = 1'b0;
        lfsrState   = 32'h2900_6f1c;
        errorCount  = 0;
        checkCount  = 0;
        testsLoaded = 1'b0;
        loadTests();
        if (opList.size() == 0) begin
            errorCount++;
            $display("no test lines were loaded");
        end
        timeoutCycles = (opList.size() + 1) * cyclesPerLine;
        testsLoaded   = 1'b1;
        // reset held for 3 cycles
        idleClocks(3);
        reset = 1'b0;
        idleClocks(2);
        checkMisoEnable(1'b0, "after reset");
        checkCount++;
        assert (miso === 1'b0) else begin
            errorCount++;
            $display("Fail miso after reset: expected %h, actual %h", 1'b0, miso);
        end
        foreach (opList[n]) begin
            runTransaction(opList[n], addrList[n], dataList[n], abortList[n]);
        end
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: dv/spiMemoryTests.txt
# one SPI transaction per line: op, address (hex), data (hex), abort bit count (decimal)
# W write, R read checked against the model, A write released early, G write with glitches
W 05 a5 0
R 05 00 0
W 00 3c 0
W 7f c3 0
W 40 ff 0
W 01 00 0
R 00 00 0
R 7f 00 0
R 40 00 0
R 01 00 0
W 2a 96 0
A 2a 11 3
R 2a 00 0
A 2a 22 8
R 2a 00 0
A 2a 33 12
R 2a 00 0
A 7f 5a 12
R 7f 00 0
A 00 81 8
R 00 00 0
G 10 b7 0
R 10 00 0
G 7e 4d 0
R 7e 00 0
G 00 e1 0
R 00 00 0
W 55 aa 0
W 2b 55 0
R 55 00 0
R 2b 00 0
W 05 5a 0
R 05 00 0
A 05 ff 3
R 05 00 0
G 3f 00 0
R 3f 00 0
W 63 81 0
R 63 00 0
R 7f 00 0
R 2a 00 0
R 40 00 0

// File: source/dataMemory.sv
// byte-wide data memory with address latch, written and read by the SPI controller
`timescale 1ns/10ps

module dataMemory import spiMemoryPkg::*; #(
    parameter int addrWidth = 7
) (
    input  logic                   clk,
    input  logic                   addrWe,
    input  logic [addrWidth-1:0]   addressIn,
    input  logic                   memWe,
    input  logic [bitsPerByte-1:0] writeData,
    output logic [bitsPerByte-1:0] readData
);

    localparam int depth = 1 << addrWidth;

    logic [addrWidth-1:0]   latchedAddress;
    logic [bitsPerByte-1:0] memArray [depth];

    // address latch
    // captured once per transaction after the address phase
    always_ff @(posedge clk) begin
        if (addrWe) begin
            latchedAddress <= addressIn;
        end
    end

    // write port at the latched address
    always_ff @(posedge clk) begin
        if (memWe) begin
            memArray[latchedAddress] <= writeData;
        end
    end

    // asynchronous read, ready for the parallel load one cycle after the latch
    assign readData = memArray[latchedAddress];

endmodule

// File: source/inputConditioner.sv
// synchronizes and debounces one asynchronous SPI pin, giving a clean level and edge pulses
`timescale 1ns/10ps

module inputConditioner #(
    parameter int waitCycles = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic noisy,
    input  logic resetLevel,
    output logic conditioned,
    output logic positiveEdge,
    output logic negativeEdge
);

    // counter must reach waitCycles
    localparam int counterWidth = $clog2(waitCycles + 1);

    logic                    syncStage0;
    logic                    syncStage1;
    logic [counterWidth-1:0] stableCount;

    // two-flop synchronizer
    // idles at the pin's rest level so reset release makes no false edge
    always_ff @(posedge clk) begin
        if (reset) begin
            syncStage0 <= resetLevel;
            syncStage1 <= resetLevel;
        end else begin
            syncStage0 <= noisy;
            syncStage1 <= syncStage0;
        end
    end

    // debounce filter
    // a new value must hold for waitCycles + 1 samples before it is accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            conditioned  <= resetLevel;
            stableCount  <= '0;
            positiveEdge <= 1'b0;
            negativeEdge <= 1'b0;
        end else begin
            // edge pulses last one cycle by default
            positiveEdge <= 1'b0;
            negativeEdge <= 1'b0;
            if (syncStage1 == conditioned) begin
                // input back at the accepted value, glitch is dropped
                stableCount <= '0;
            end else if (stableCount == counterWidth'(waitCycles)) begin
                // stable long enough, accept it
                conditioned  <= syncStage1;
                positiveEdge <= syncStage1;
                negativeEdge <= ~syncStage1;
                stableCount  <= '0;
            end else begin
                stableCount <= stableCount + 1'b1;
            end
        end
    end

endmodule

// File: source/shiftRegister.sv
// SPI shift register: serial in from mosi, parallel load for reads, registered miso bit
`timescale 1ns/10ps

module shiftRegister import spiMemoryPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sclkPos,
    input  logic                   sclkNeg,
    input  logic                   serialIn,
    input  logic                   parallelLoad,
    input  logic [bitsPerByte-1:0] parallelIn,
    output logic [bitsPerByte-1:0] parallelOut,
    output logic                   miso
);

    // shift data
    // mosi is sampled on the sclk rising edge, MSB arrives first
    // parallel load wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (parallelLoad) begin
            parallelOut <= parallelIn;
        end else if (sclkPos) begin
            parallelOut <= {parallelOut[bitsPerByte-2:0], serialIn};
        end
    end

    // miso output flop
    // mode 0 slave changes miso after the falling edge
    // a load presents its MSB at once, so the first bit is ready early
    always_ff @(posedge clk) begin
        if (reset) begin
            miso <= 1'b0;
        end else if (parallelLoad) begin
            miso <= parallelIn[bitsPerByte-1];
        end else if (sclkNeg) begin
            // register already shifted past the bit the master just took
            miso <= parallelOut[bitsPerByte-1];
        end
    end

endmodule

// File: source/spiControlFsm.sv
// SPI transaction controller: counts sclk bits and strobes address latch, load and memory write
`timescale 1ns/10ps

module spiControlFsm import spiMemoryPkg::*; #(
    parameter int addrWidth = 7
) (
    input  logic clk,
    input  logic reset,
    input  logic sclkPos,
    input  logic csLevel,
    input  logic readWrite,
    output logic addrWe,
    output logic parallelLoad,
    output logic memWe,
    output logic misoEnable
);

    // address phase carries the address plus the read/write bit
    localparam int addrBits = addrWidth + 1;
    localparam logic [countWidth-1:0] lastAddrBit = countWidth'(addrBits - 1);
    localparam logic [countWidth-1:0] lastDataBit = countWidth'(bitsPerByte - 1);

    controlState             state;
    logic [countWidth-1:0]   bitCount;
    logic [countWidth-1:0]   lastBit;
    logic                    counting;
    logic                    phaseEnd;

    // only the three shifting states count sclk rising edges
    assign counting = (state == getAddress) || (state == readShift) ||
                      (state == writeShift);

    // address phase may differ in length from a data phase
    assign lastBit = (state == getAddress) ? lastAddrBit : lastDataBit;

    // final bit of the current phase is being sampled this cycle
    assign phaseEnd = counting && sclkPos && (bitCount == lastBit);

    // bit counter
    // runs on the system clock with the FSM
    // chip select high holds it at zero
    always_ff @(posedge clk) begin
        if (reset || csLevel) begin
            bitCount <= '0;
        end else if (counting && sclkPos) begin
            if (phaseEnd) begin
                bitCount <= '0;
            end else begin
                bitCount <= bitCount + 1'b1;
            end
        end
    end

    // state register
    // chip select release abandons the transaction from any state
    always_ff @(posedge clk) begin
        if (reset || csLevel) begin
            state      <= getAddress;
            misoEnable <= 1'b0;
        end else begin
            case (state)
                getAddress: begin
                    // full byte shifted in, address and rw bit now in place
                    if (phaseEnd) begin
                        state <= latchAddress;
                    end
                end
                latchAddress: begin
                    // rw bit sits in the shift register LSB
                    if (readWrite) begin
                        state      <= readLoad;
                        // drive miso from here until chip select rises
                        misoEnable <= 1'b1;
                    end else begin
                        state <= writeShift;
                    end
                end
                readLoad: begin
                    state <= readShift;
                end
                readShift: begin
                    // master has sampled all eight read bits
                    if (phaseEnd) begin
                        state <= done;
                    end
                end
                writeShift: begin
                    // eighth data bit shifted, commit next cycle
                    if (phaseEnd) begin
                        state <= writeCommit;
                    end
                end
                writeCommit: begin
                    state <= done;
                end
                done: begin
                    // hold until chip select release
                    state <= done;
                end
                default: begin
                    state <= getAddress;
                end
            endcase
        end
    end

    // single-cycle strobes decode straight from the one-hot state
    assign addrWe       = (state == latchAddress);
    assign parallelLoad = (state == readLoad);
    assign memWe        = (state == writeCommit);

endmodule

// File: source/spiMemory.sv
// top level of the SPI slave byte memory: pin conditioning, shift register, controller, memory
`timescale 1ns/10ps

module spiMemory import spiMemoryPkg::*; #(
    parameter int addrWidth  = 7,
    parameter int waitCycles = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoEnable
);

    // conditioned pins
    logic sclkPos;
    logic sclkNeg;
    logic csLevel;
    logic mosiLevel;

    // datapath and control
    logic [bitsPerByte-1:0] parallelOut;
    logic [bitsPerByte-1:0] memReadData;
    logic                   addrWe;
    logic                   parallelLoad;
    logic                   memWe;

    // sclk only matters as edge pulses, idles low in mode 0
    inputConditioner #(
        .waitCycles(waitCycles)
    ) sclkConditioner (
        .clk         (clk),
        .reset       (reset),
        .noisy       (sclk),
        .resetLevel  (1'b0),
        .conditioned (),
        .positiveEdge(sclkPos),
        .negativeEdge(sclkNeg)
    );

    // chip select idles high, so no transaction starts out of reset
    inputConditioner #(
        .waitCycles(waitCycles)
    ) csConditioner (
        .clk         (clk),
        .reset       (reset),
        .noisy       (csN),
        .resetLevel  (1'b1),
        .conditioned (csLevel),
        .positiveEdge(),
        .negativeEdge()
    );

    inputConditioner #(
        .waitCycles(waitCycles)
    ) mosiConditioner (
        .clk         (clk),
        .reset       (reset),
        .noisy       (mosi),
        .resetLevel  (1'b0),
        .conditioned (mosiLevel),
        .positiveEdge(),
        .negativeEdge()
    );

    shiftRegister shifter (
        .clk         (clk),
        .reset       (reset),
        .sclkPos     (sclkPos),
        .sclkNeg     (sclkNeg),
        .serialIn    (mosiLevel),
        .parallelLoad(parallelLoad),
        .parallelIn  (memReadData),
        .parallelOut (parallelOut),
        .miso        (miso)
    );

    // rw bit is the last one shifted in, so it lands in the LSB
    spiControlFsm #(
        .addrWidth(addrWidth)
    ) controller (
        .clk         (clk),
        .reset       (reset),
        .sclkPos     (sclkPos),
        .csLevel     (csLevel),
        .readWrite   (parallelOut[0]),
        .addrWe      (addrWe),
        .parallelLoad(parallelLoad),
        .memWe       (memWe),
        .misoEnable  (misoEnable)
    );

    // address sits above the rw bit in the shift register
    dataMemory #(
        .addrWidth(addrWidth)
    ) memory (
        .clk      (clk),
        .addrWe   (addrWe),
        .addressIn(parallelOut[bitsPerByte-1 -: addrWidth]),
        .memWe    (memWe),
        .writeData(parallelOut),
        .readData (memReadData)
    );

endmodule

// File: source/spiMemoryPkg.sv
// shared constants and controller state type for the SPI memory, imported by its RTL modules
package spiMemoryPkg;

    // sclk cycles in one address or data phase
    localparam int bitsPerByte = 8;

    // bit counter width, wide enough to hold bitsPerByte
    localparam int countWidth = 4;

    // controller states, one-hot so each strobe decodes from a single bit
    typedef enum logic [6:0] {
        // shifting in address and read/write bit
        getAddress   = 7'b0000001,
        // address byte complete, strobe the address latch
        latchAddress = 7'b0000010,
        // copy the addressed byte into the shift register
        readLoad     = 7'b0000100,
        // master clocks the read byte out on miso
        readShift    = 7'b0001000,
        // master clocks the write byte in on mosi
        writeShift   = 7'b0010000,
        // write byte complete, strobe the memory write
        writeCommit  = 7'b0100000,
        // wait here for chip select release
        done         = 7'b1000000
    } controlState;

endpackage

// File: spiMemory.f
source/spiMemoryPkg.sv
source/inputConditioner.sv
source/shiftRegister.sv
source/spiControlFsm.sv
source/dataMemory.sv
source/spiMemory.sv
dv/spiMemoryTb.sv
